// File: logic/lc3IsaPkg.sv
/* Instruction set definitions of the teaching processor:
   opcode encodings and ALU function codes */
`default_nettype none

package lc3IsaPkg;

    typedef logic [3:0] opcode_t;   // IR[15:12]
    typedef logic [1:0] aluOp_t;

    // Opcodes still served by the control unit
    localparam opcode_t opBr  = 4'b0000;
    localparam opcode_t opAdd = 4'b0001;
    localparam opcode_t opLd  = 4'b0010;
    localparam opcode_t opSt  = 4'b0011;
    localparam opcode_t opAnd = 4'b0101;
    localparam opcode_t opLdr = 4'b0110;
    localparam opcode_t opStr = 4'b0111;
    localparam opcode_t opNot = 4'b1001;
    localparam opcode_t opLdi = 4'b1010;
    localparam opcode_t opSti = 4'b1011;
    localparam opcode_t opJmp = 4'b1100;
    localparam opcode_t opMul = 4'b1101;   // Extension opcode
    localparam opcode_t opLea = 4'b1110;

    // ALU function select
    localparam aluOp_t aluAdd  = 2'd0;
    localparam aluOp_t aluAnd  = 2'd1;
    localparam aluOp_t aluNot  = 2'd2;
    localparam aluOp_t aluPass = 2'd3;   // Passes SR1 through, used for stores

endpackage

`default_nettype wire

// File: logic/controlPkg.sv
/* Control unit definitions: control-state enum, datapath select types
   and the fixed memory access length */
`default_nettype none

package controlPkg;

    typedef enum logic [4:0] {
        sFetchAddr,     // MAR <- PC, PC <- PC + 1
        sFetchMem,
        sFetchIr,
        sDecode,
        sBrTest,
        sBrTaken,
        sAdd,
        sAnd,
        sNot,
        sLdAddr,
        sLdrAddr,
        sLdiAddr,
        sLdiMem,        // Fetch of the pointer word
        sLdiPtr,
        sStAddr,
        sStrAddr,
        sStiAddr,
        sStiMem,
        sStiPtr,
        sStoreData,     // Shared by ST, STR and STI
        sStoreMem,
        sLoadMem,       // Shared by LD, LDR and LDI
        sLoadReg,
        sJmp,
        sLea,
        sMulStart,
        sMulWait,
        sMulWrite,
        sInvalid,
        sStart,
        sHalt
    } ctrlState_t;

    // Second adder operand
    typedef logic [1:0] addr2Sel_t;
    localparam addr2Sel_t addr2Zero = 2'd0;
    localparam addr2Sel_t addr2Off6 = 2'd1;
    localparam addr2Sel_t addr2Off9 = 2'd2;

    // PC source
    typedef logic [1:0] pcSel_t;
    localparam pcSel_t pcInc   = 2'd0;
    localparam pcSel_t pcAdder = 2'd2;

    localparam int memWaitCycles = 3;   // Cycles per memory access
    typedef logic [1:0] memWaitCount_t;

endpackage

`default_nettype wire

// File: logic/memWaitTimer.sv
/* Wait counter for the fixed-latency memory */
`default_nettype none

module memWaitTimer
    import controlPkg::*;
(
    input  logic Clk,
    input  logic rstN,
    input  logic memAccess,
    output logic memReady
);

    localparam memWaitCount_t lastCount = memWaitCount_t'(memWaitCycles - 1);

    memWaitCount_t count;

    // Last cycle of the access
    assign memReady = memAccess && (count == lastCount);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            count <= '0;
        end else if (!memAccess || memReady) begin
            count <= '0;    // Ready for the next access
        end else begin
            count <= count + memWaitCount_t'(1);
        end
    end

endmodule

`default_nettype wire

// File: logic/controlSequencer.sv
/* Control state register with the fetch, decode and execute
   transitions, plus the memory access flag for the wait timer */
`default_nettype none

module controlSequencer
    import lc3IsaPkg::*;
    import controlPkg::*;
(
    input  logic       Clk,
    input  logic       rstN,
    input  logic       run,
    input  logic       cont,
    input  opcode_t    opcode,
    input  logic       ben,
    input  logic       mulReady,
    input  logic       memReady,
    output ctrlState_t state,
    output logic       memAccess
);

    ctrlState_t nextState;

    assign memAccess = (state == sFetchMem) || (state == sLdiMem) || (state == sStiMem)
                    || (state == sLoadMem) || (state == sStoreMem);

    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= sHalt;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;  // Hold by default

        case (state)
            sFetchAddr: nextState = sFetchMem;
            sFetchMem:  nextState = memReady ? sFetchIr : sFetchMem;
            sFetchIr:   nextState = sDecode;

            sDecode: begin
                case (opcode)
                    opBr:    nextState = sBrTest;
                    opAdd:   nextState = sAdd;
                    opLd:    nextState = sLdAddr;
                    opSt:    nextState = sStAddr;
                    opAnd:   nextState = sAnd;
                    opLdr:   nextState = sLdrAddr;
                    opStr:   nextState = sStrAddr;
                    opNot:   nextState = sNot;
                    opLdi:   nextState = sLdiAddr;
                    opSti:   nextState = sStiAddr;
                    opJmp:   nextState = sJmp;
                    opMul:   nextState = sMulStart;
                    opLea:   nextState = sLea;
                    default: nextState = sInvalid;  // Includes the former JSR and TRAP
                endcase
            end

            sBrTest: nextState = ben ? sBrTaken : sFetchAddr;

            sBrTaken, sAdd, sAnd, sNot, sJmp, sLea:
                nextState = sFetchAddr;

            // Loads
            sLdAddr, sLdrAddr: nextState = sLoadMem;
            sLdiAddr:          nextState = sLdiMem;
            sLdiMem:           nextState = memReady ? sLdiPtr : sLdiMem;
            sLdiPtr:           nextState = sLoadMem;
            sLoadMem:          nextState = memReady ? sLoadReg : sLoadMem;
            sLoadReg:          nextState = sFetchAddr;

            // Stores
            sStAddr, sStrAddr: nextState = sStoreData;
            sStiAddr:          nextState = sStiMem;
            sStiMem:           nextState = memReady ? sStiPtr : sStiMem;
            sStiPtr:           nextState = sStoreData;
            sStoreData:        nextState = sStoreMem;
            sStoreMem:         nextState = memReady ? sFetchAddr : sStoreMem;

            // Multiplier has variable latency
            sMulStart: nextState = sMulWait;
            sMulWait:  nextState = mulReady ? sMulWrite : sMulWait;
            sMulWrite: nextState = sFetchAddr;

            sInvalid: nextState = cont ? sHalt : sInvalid;   // Wait for acknowledge
            sStart:   nextState = run ? sStart : sFetchAddr;
            sHalt:    nextState = run ? sStart : sHalt;

            default: nextState = sHalt;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/controlWordDecoder.sv
/* Control word decode: datapath loads, bus gates, mux selects and
   memory strobes for each control state */
`default_nettype none

module controlWordDecoder
    import lc3IsaPkg::*;
    import controlPkg::*;
(
    input  ctrlState_t state,
    input  logic       memReady,
    output logic       ldMar,
    output logic       ldMdr,
    output logic       ldIr,
    output logic       ldBen,
    output logic       ldReg,
    output logic       ldCc,
    output logic       ldPc,
    output logic       gatePc,
    output logic       gateMdr,
    output logic       gateMul,
    output logic       gateAlu,
    output logic       gateMarMux,
    output logic       addr1Mux,
    output logic       marMux,
    output logic       sr1Mux,
    output logic       mioEn,
    output logic       rW,
    output logic       mulEn,
    output logic       halted,
    output logic       paused,
    output logic       invalid,
    output addr2Sel_t  addr2Mux,
    output pcSel_t     pcMux,
    output aluOp_t     aluK
);

    always_comb begin
        ldMar      = 1'b0;
        ldMdr      = 1'b0;
        ldIr       = 1'b0;
        ldBen      = 1'b0;
        ldReg      = 1'b0;
        ldCc       = 1'b0;
        ldPc       = 1'b0;
        gatePc     = 1'b0;
        gateMdr    = 1'b0;
        gateMul    = 1'b0;
        gateAlu    = 1'b0;
        gateMarMux = 1'b0;
        addr1Mux   = 1'b0;  // PC as first adder operand
        marMux     = 1'b0;
        sr1Mux     = 1'b0;  // IR[11:9]
        mioEn      = 1'b0;
        rW         = 1'b0;
        mulEn      = 1'b0;
        halted     = 1'b0;
        paused     = 1'b0;
        invalid    = 1'b0;
        addr2Mux   = addr2Zero;
        pcMux      = pcInc;
        aluK       = aluAdd;

        case (state)
            sFetchAddr: begin
                gatePc = 1'b1;
                ldMar  = 1'b1;
                ldPc   = 1'b1;
                pcMux  = pcInc;
            end
            sFetchIr: begin
                gateMdr = 1'b1;
                ldIr    = 1'b1;
                paused  = 1'b1;
            end
            sDecode: ldBen = 1'b1;

            // Memory reads capture MDR on the last cycle
            sFetchMem, sLdiMem, sStiMem, sLoadMem: begin
                mioEn = 1'b1;
                ldMdr = memReady;
            end
            sStoreMem: begin
                mioEn = 1'b1;
                rW    = 1'b1;   // Held through the whole write
            end

            sBrTaken: begin
                addr2Mux = addr2Off9;
                pcMux    = pcAdder;
                ldPc     = 1'b1;
            end

            sAdd, sAnd, sNot: begin
                sr1Mux  = 1'b1;
                gateAlu = 1'b1;
                ldReg   = 1'b1;
                ldCc    = 1'b1;
                if (state == sAnd) begin
                    aluK = aluAnd;
                end else if (state == sNot) begin
                    aluK = aluNot;
                end else begin
                    aluK = aluAdd;
                end
            end

            sLdAddr, sLdiAddr, sStAddr, sStiAddr: begin   // MAR <- PC + off9
                addr2Mux   = addr2Off9;
                marMux     = 1'b1;
                gateMarMux = 1'b1;
                ldMar      = 1'b1;
            end
            sLdrAddr, sStrAddr: begin   // MAR <- BaseR + off6
                sr1Mux     = 1'b1;
                addr1Mux   = 1'b1;
                addr2Mux   = addr2Off6;
                marMux     = 1'b1;
                gateMarMux = 1'b1;
                ldMar      = 1'b1;
            end
            sLdiPtr, sStiPtr: begin
                gateMdr = 1'b1;
                ldMar   = 1'b1;
            end
            sStoreData: begin
                aluK    = aluPass;
                gateAlu = 1'b1;
                ldMdr   = 1'b1;
            end
            sLoadReg: begin
                gateMdr = 1'b1;
                ldReg   = 1'b1;
                ldCc    = 1'b1;
            end

            sJmp: begin
                sr1Mux   = 1'b1;
                addr1Mux = 1'b1;
                addr2Mux = addr2Zero;
                pcMux    = pcAdder;
                ldPc     = 1'b1;
            end
            sLea: begin
                addr2Mux   = addr2Off9;
                marMux     = 1'b1;
                gateMarMux = 1'b1;
                ldReg      = 1'b1;
                ldCc       = 1'b1;
            end

            sMulStart: begin
                sr1Mux = 1'b1;
                mulEn  = 1'b1;
            end
            sMulWrite: begin
                gateMul = 1'b1;
                ldReg   = 1'b1;
                ldCc    = 1'b1;
            end

            sInvalid: invalid = 1'b1;
            sHalt:    halted  = 1'b1;
            default: ;  // Idle states drive nothing
        endcase
    end

endmodule

`default_nettype wire

// File: logic/controlUnit.sv
/* Control unit top: sequencer, memory wait timer and control word decoder */
`default_nettype none

module controlUnit
    import lc3IsaPkg::*;
    import controlPkg::*;
(
    input  logic      Clk,
    input  logic      rstN,
    input  logic      run,
    input  logic      cont,
    input  opcode_t   opcode,
    input  logic      ben,
    input  logic      mulReady,
    output logic      ldMar,
    output logic      ldMdr,
    output logic      ldIr,
    output logic      ldBen,
    output logic      ldReg,
    output logic      ldCc,
    output logic      ldPc,
    output logic      gatePc,
    output logic      gateMdr,
    output logic      gateMul,
    output logic      gateAlu,
    output logic      gateMarMux,
    output logic      addr1Mux,
    output logic      marMux,
    output logic      sr1Mux,
    output logic      mioEn,
    output logic      rW,
    output logic      mulEn,
    output logic      halted,
    output logic      paused,
    output logic      invalid,
    output addr2Sel_t addr2Mux,
    output pcSel_t    pcMux,
    output aluOp_t    aluK
);

    ctrlState_t state;
    logic       memAccess;
    logic       memReady;

    controlSequencer sequencer_i (
        .Clk       (Clk),
        .rstN      (rstN),
        .run       (run),
        .cont      (cont),
        .opcode    (opcode),
        .ben       (ben),
        .mulReady  (mulReady),
        .memReady  (memReady),
        .state     (state),
        .memAccess (memAccess)
    );

    memWaitTimer timer_i (
        .Clk       (Clk),
        .rstN      (rstN),
        .memAccess (memAccess),
        .memReady  (memReady)
    );

    controlWordDecoder decoder_i (
        .state      (state),
        .memReady   (memReady),
        .ldMar      (ldMar),
        .ldMdr      (ldMdr),
        .ldIr       (ldIr),
        .ldBen      (ldBen),
        .ldReg      (ldReg),
        .ldCc       (ldCc),
        .ldPc       (ldPc),
        .gatePc     (gatePc),
        .gateMdr    (gateMdr),
        .gateMul    (gateMul),
        .gateAlu    (gateAlu),
        .gateMarMux (gateMarMux),
        .addr1Mux   (addr1Mux),
        .marMux     (marMux),
        .sr1Mux     (sr1Mux),
        .mioEn      (mioEn),
        .rW         (rW),
        .mulEn      (mulEn),
        .halted     (halted),
        .paused     (paused),
        .invalid    (invalid),
        .addr2Mux   (addr2Mux),
        .pcMux      (pcMux),
        .aluK       (aluK)
    );

endmodule

`default_nettype wire

// File: dv/controlUnitTb.sv
/* Random-stimulus testbench for the control unit with an instruction-level
   reference model of execute lengths, strobe counts and memory accesses */
`default_nettype none

module controlUnitTb
    import lc3IsaPkg::*;
    import controlPkg::*;
;

    localparam int numInstr    = 300;
    localparam int worstCycles = 32;    // Longest fetch + execute, incl. invalid and restart
    localparam int timeoutTime = (numInstr + 2) * worstCycles * 20;

    logic      Clk;
    logic      rstN;
    logic      run;
    logic      cont;
    opcode_t   opcode;
    logic      ben;
    logic      mulReady;
    logic      ldMar, ldMdr, ldIr, ldBen, ldReg, ldCc, ldPc;
    logic      gatePc, gateMdr, gateMul, gateAlu, gateMarMux;
    logic      addr1Mux, marMux, sr1Mux, mioEn, rW, mulEn;
    logic      halted, paused, invalid;
    addr2Sel_t addr2Mux;
    pcSel_t    pcMux;
    aluOp_t    aluK;

    integer seed;
    int     errors;
    int     instrCount;
    int     regLoads, ccLoads, pcLoads, memRuns, writeCycles, runLen;
    logic   runIsStore;

    controlUnit dut_i (.*);

    initial Clk = 1'b0;
    always #10 Clk = ~Clk;

    initial begin
        #(timeoutTime);
        $display("Watchdog expired: the DUT stopped making progress before all instructions ran");
        $display(">>> FAIL");
        $finish;
    end

    task automatic compare(input int actual, input int expected, input string what);
        if (actual != expected) begin
            errors++;
            $display("MISMATCH at time %0t: %s: got %0d, expected %0d",
                     $time, what, actual, expected);
        end
    endtask

    function automatic logic isValidOpcode(opcode_t op);
        case (op)
            opBr, opAdd, opLd, opSt, opAnd, opLdr, opStr, opNot,
            opLdi, opSti, opJmp, opMul, opLea: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Reference execute lengths, counted after decode
    function automatic int execLength(opcode_t op, logic takeBr, int mulWait);
        case (op)
            opAdd, opAnd, opNot, opJmp, opLea: return 1;
            opBr:         return takeBr ? 2 : 1;
            opLd, opLdr:  return 1 + memWaitCycles + 1;
            opLdi:        return 1 + memWaitCycles + 1 + memWaitCycles + 1;
            opSt, opStr:  return 1 + 1 + memWaitCycles;
            opSti:        return 1 + memWaitCycles + 1 + 1 + memWaitCycles;
            opMul:        return 1 + mulWait + 1;
            default:      return 0;
        endcase
    endfunction

    function automatic int regWrites(opcode_t op);
        case (op)
            opAdd, opAnd, opNot, opLea, opLd, opLdr, opLdi, opMul: return 1;
            default: return 0;
        endcase
    endfunction

    function automatic int memAccesses(opcode_t op);
        case (op)
            opLd, opLdr, opSt, opStr: return 1;
            opLdi, opSti:             return 2;
            default:                  return 0;
        endcase
    endfunction

    function automatic int storeCycles(opcode_t op);
        return (op == opSt || op == opStr || op == opSti) ? memWaitCycles : 0;
    endfunction

    function automatic aluOp_t expectedAluOp(opcode_t op);
        case (op)
            opAnd:   return aluAnd;
            opNot:   return aluNot;
            default: return aluAdd;
        endcase
    endfunction

    function automatic logic [25:0] outputsBesidesHalted();
        return {ldMar, ldMdr, ldIr, ldBen, ldReg, ldCc, ldPc, gatePc, gateMdr, gateMul,
                gateAlu, gateMarMux, addr1Mux, marMux, sr1Mux, mioEn, rW, mulEn, paused,
                invalid, addr2Mux, pcMux, aluK};
    endfunction

    // Most invalid codes get a second draw so they come up rarely
    task automatic pickOpcode(output opcode_t op);
        op = opcode_t'($random(seed));
        if (!isValidOpcode(op) && (($random(seed) & 3) != 0)) begin
            op = opcode_t'($random(seed));
        end
    endtask

    // One clock, then sample; also tracks strobe counts and memory accesses
    task automatic step;
        @(posedge Clk);
        #2;
        if (ldReg) regLoads++;
        if (ldCc) ccLoads++;
        if (ldPc) pcLoads++;
        if (mioEn) begin
            runLen++;
            if (runLen == 1) runIsStore = rW;
            compare(int'(rW), int'(runIsStore), "rW steady through an access");
            compare(int'(ldMdr), int'(!runIsStore && runLen == memWaitCycles),
                    "ldMdr only on the last read cycle");
            if (rW) writeCycles++;
        end else begin
            compare(int'(rW), 0, "rW outside an access");
            if (runLen != 0) begin
                compare(runLen, memWaitCycles, "memory access length");
                memRuns++;
                runLen = 0;
            end
        end
    endtask

    // Starts in sHalt, ends on the first fetch cycle
    task automatic startRun;
        repeat (3) begin
            step();
            compare(int'(halted), 1, "halted while idle");
            compare(int'(outputsBesidesHalted()), 0, "outputs low while halted");
        end
        run = 1'b1;
        step();
        compare(int'(halted), 0, "halted left on run");
        compare(int'(outputsBesidesHalted()), 0, "outputs low in start");
        run = 1'b0;
        step();
        compare(int'(ldMar && gatePc && ldPc), 1, "first fetch after run drops");
    endtask

    task automatic handleInvalid;
        int holdCycles;
        holdCycles = 1 + $unsigned($random(seed)) % 3;
        repeat (holdCycles) begin
            step();
            compare(int'(invalid), 1, "invalid held until cont");
            compare(int'(halted), 0, "halted before cont");
        end
        cont = 1'b1;
        step();
        compare(int'(halted), 1, "halted after cont");
        compare(int'(invalid), 0, "invalid cleared after cont");
        cont = 1'b0;
        startRun();
    endtask

    // Starts on a fetch ldMar cycle, ends on the next one
    task automatic runInstruction;
        int      gap;
        int      mulStart;
        int      mulEnd;
        int      mulDelay;
        int      mulDrawn;
        logic    mulPending;
        logic    takeBr;
        opcode_t op;
        gap = 0;
        do begin
            step();
            gap++;
        end while (!ldIr);
        compare(gap, memWaitCycles + 1, "cycles from fetch ldMar to ldIr");
        pickOpcode(op);
        opcode      = op;   // IR now holds the new word
        regLoads    = 0;
        ccLoads     = 0;
        pcLoads     = 0;
        memRuns     = 0;
        writeCycles = 0;
        step();
        compare(int'(ldBen), 1, "ldBen in decode");
        takeBr = 1'($random(seed));
        ben    = takeBr;
        if (!isValidOpcode(op)) begin
            handleInvalid();
            return;
        end
        gap        = 1;
        mulPending = 1'b0;
        mulStart   = 0;
        mulEnd     = 0;
        mulDrawn   = 0;
        do begin
            step();
            gap++;
            if (mulPending && !mulReady) begin
                if (mulDelay == 0) mulReady = 1'b1;
                else mulDelay--;
            end
            if (mulEn) begin
                mulStart   = gap;
                mulDrawn   = $unsigned($random(seed)) % 6;
                mulDelay   = mulDrawn;
                mulPending = 1'b1;
            end
            if (gateMul) begin
                mulEnd     = gap;
                mulReady   = 1'b0;
                mulPending = 1'b0;
            end
            if (gateAlu && ldReg) begin
                compare(int'(aluK), int'(expectedAluOp(op)), "aluK for ALU operation");
            end
        end while (!(ldMar && gatePc));     // Address loads of MAR do not end the instruction
        // Wait state sees mulReady low for mulDrawn cycles, then high once
        compare(gap, 2 + execLength(op, takeBr, mulDrawn + 1), "ldIr to next fetch ldMar");
        if (op == opMul) begin
            compare(mulEnd - mulStart, 2 + mulDrawn, "mulEn to gateMul");
        end
        compare(regLoads, regWrites(op), "ldReg pulses");
        compare(ccLoads, regWrites(op), "ldCc pulses");
        // Count includes the PC increment of the next fetch
        compare(pcLoads, 1 + int'((op == opBr && takeBr) || op == opJmp), "ldPc pulses");
        compare(memRuns, memAccesses(op), "memory accesses");
        compare(writeCycles, storeCycles(op), "rW cycles");
    endtask

    initial begin
        seed        = 32'ha06b_f612;
        errors      = 0;
        runLen      = 0;
        runIsStore  = 1'b0;
        rstN        = 1'b0;
        run         = 1'b0;
        cont        = 1'b0;
        opcode      = opBr;
        ben         = 1'b0;
        mulReady    = 1'b0;
        repeat (4) @(posedge Clk);
        #2;
        rstN = 1'b1;
        compare(int'(halted), 1, "halted after reset");
        startRun();
        for (instrCount = 0; instrCount < numInstr; instrCount++) begin
            runInstruction();
        end
        $display("Ran %0d instructions, %0d errors", instrCount, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: controlUnit.f
logic/lc3IsaPkg.sv
logic/controlPkg.sv
logic/memWaitTimer.sv
logic/controlSequencer.sv
logic/controlWordDecoder.sv
logic/controlUnit.sv
dv/controlUnitTb.sv

// File: Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f controlUnit.f --top-module controlUnitTb -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/VcontrolUnitTb | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
